/* core_defines.svh */
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data path and address width
`define XLEN 32

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Depth of the internal data RAM in 32-bit words
`define RAM_WORDS 64

// Stores at or above this byte address leave through the MMIO write port
`define MMIO_BASE 32'h400

`endif

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_WORD    = 3'b010;
    localparam logic [6:0] F7_ADD     = 7'b0000000;
    localparam logic [6:0] F7_SUB     = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_format_t;

    // I and S share imm_hi; the low five bits sit where rs2 (I) or rd (S) would be
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] imm_lo_i;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo_s;
        logic [6:0] opcode;
    } is_format_t;

    typedef union packed {
        logic [31:0] raw;
        r_format_t   r_fmt;
        is_format_t  is_fmt;
    } instr_word_u;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

`include "core_defines.svh"

package pipe_pkg;

    typedef logic [$clog2(`REG_COUNT)-1:0] reg_idx_t;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_ADDI,
        OP_LOAD,
        OP_STORE
    } alu_op_t;

    // Decode to execute, immediate already sign extended
    typedef struct packed {
        logic             valid;
        alu_op_t          op;
        reg_idx_t         rd;
        reg_idx_t         rs1;
        reg_idx_t         rs2;
        logic [`XLEN-1:0] imm;
    } decoded_t;

    // Execute to memory; result doubles as the address of loads and stores
    typedef struct packed {
        logic             valid;
        logic             is_load;
        logic             is_store;
        reg_idx_t         rd;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] store_data;
    } mem_req_t;

    typedef struct packed {
        logic             enable;
        reg_idx_t         rd;
        logic [`XLEN-1:0] value;
    } reg_write_t;

endpackage

`default_nettype wire

/* pipe_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

// Results still in flight in the memory and writeback stages
interface fwd_if;
    logic               m_valid;
    logic               m_is_load;
    pipe_pkg::reg_idx_t m_rd;
    logic [`XLEN-1:0]   m_value;
    logic               w_valid;
    pipe_pkg::reg_idx_t w_rd;
    logic [`XLEN-1:0]   w_value;

    modport producer (
        output m_valid, m_is_load, m_rd, m_value,
        output w_valid, w_rd, w_value
    );

    modport consumer (
        input m_valid, m_is_load, m_rd, m_value,
        input w_valid, w_rd, w_value
    );
endinterface

`default_nettype wire

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  logic [`XLEN-1:0]     instr_bits,
    input  logic                 stall,
    input  pipe_pkg::reg_write_t reg_write,
    output pipe_pkg::decoded_t   decoded,
    output logic [`XLEN-1:0]     rs1_value,
    output logic [`XLEN-1:0]     rs2_value
);
    rv_isa_pkg::instr_word_u word;
    pipe_pkg::decoded_t      decoded_next;
    logic                    known;
    logic [`XLEN-1:0]        imm_i;
    logic [`XLEN-1:0]        imm_s;
    logic [`XLEN-1:0]        regs [`REG_COUNT];

    // ==================================================
    // Instruction decode
    // ==================================================
    always_comb begin
        word.raw = instr_bits;
        imm_i = {{(`XLEN-12){word.is_fmt.imm_hi[6]}}, word.is_fmt.imm_hi, word.is_fmt.imm_lo_i};
        imm_s = {{(`XLEN-12){word.is_fmt.imm_hi[6]}}, word.is_fmt.imm_hi, word.is_fmt.imm_lo_s};

        known = 1'b0;
        decoded_next = '0;
        decoded_next.rd  = word.r_fmt.rd;
        decoded_next.rs1 = word.r_fmt.rs1;
        decoded_next.rs2 = word.r_fmt.rs2;

        case (rv_isa_pkg::opcode_t'(word.r_fmt.opcode))
            rv_isa_pkg::OPC_OP: begin
                known = (word.r_fmt.funct3 == rv_isa_pkg::F3_ADD_SUB) &&
                        (word.r_fmt.funct7 == rv_isa_pkg::F7_ADD ||
                         word.r_fmt.funct7 == rv_isa_pkg::F7_SUB);
                decoded_next.op = (word.r_fmt.funct7 == rv_isa_pkg::F7_SUB) ?
                                  pipe_pkg::OP_SUB : pipe_pkg::OP_ADD;
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                known = (word.is_fmt.funct3 == rv_isa_pkg::F3_ADD_SUB);
                decoded_next.op  = pipe_pkg::OP_ADDI;
                decoded_next.imm = imm_i;
            end
            rv_isa_pkg::OPC_LOAD: begin
                known = (word.is_fmt.funct3 == rv_isa_pkg::F3_WORD);
                decoded_next.op  = pipe_pkg::OP_LOAD;
                decoded_next.imm = imm_i;
            end
            rv_isa_pkg::OPC_STORE: begin
                known = (word.is_fmt.funct3 == rv_isa_pkg::F3_WORD);
                decoded_next.op  = pipe_pkg::OP_STORE;
                decoded_next.imm = imm_s;
                // The rd field carries immediate bits, so nothing is written back
                decoded_next.rd  = '0;
            end
            default: known = 1'b0;
        endcase

        // Unknown encodings travel on as bubbles
        decoded_next.valid = instr_valid && known;
    end

    // A held stage keeps its word; otherwise take the new one or a bubble
    always_ff @(posedge clock) begin
        if (reset) begin
            decoded.valid <= 1'b0;
        end else if (!stall) begin
            decoded <= decoded_next;
        end
    end

    // ==================================================
    // Register file
    // ==================================================
    always_ff @(posedge clock) begin
        if (reg_write.enable) begin
            regs[reg_write.rd] <= reg_write.value;
        end
    end

    // Write-first read, so the retiring result is seen in the same cycle
    function automatic logic [`XLEN-1:0] read_reg(input pipe_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (reg_write.enable && reg_write.rd == idx) begin
            return reg_write.value;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1_value = read_reg(decoded.rs1);
        rs2_value = read_reg(decoded.rs2);
    end

    x0_never_written: assert property (@(posedge clock) disable iff (reset)
        reg_write.enable |-> reg_write.rd != '0)
        else $error("register x0 written with %h", reg_write.value);

endmodule

`default_nettype wire

/* execute_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_stage (
    input  logic               clock,
    input  logic               reset,
    input  pipe_pkg::decoded_t decoded,
    input  logic [`XLEN-1:0]   rs1_value,
    input  logic [`XLEN-1:0]   rs2_value,
    input  logic               frontend_stall,
    input  logic               backend_stall,
    fwd_if.consumer            fwd,
    output pipe_pkg::mem_req_t mem_req,
    output logic               load_use_hazard
);
    pipe_pkg::decoded_t ex_q;
    logic [`XLEN-1:0]   rs1_q;
    logic [`XLEN-1:0]   rs2_q;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic               uses_rs2;
    logic [`XLEN-1:0]   result;

    // Youngest producer wins; rd of zero never forwards
    function automatic logic [`XLEN-1:0] resolve_operand(
        input pipe_pkg::reg_idx_t rs,
        input logic [`XLEN-1:0]   captured
    );
        if (fwd.m_valid && fwd.m_rd != '0 && fwd.m_rd == rs) begin
            return fwd.m_value;
        end
        if (fwd.w_valid && fwd.w_rd != '0 && fwd.w_rd == rs) begin
            return fwd.w_value;
        end
        return captured;
    endfunction

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_q.valid <= 1'b0;
        end else if (!frontend_stall) begin
            ex_q  <= decoded;
            rs1_q <= rs1_value;
            rs2_q <= rs2_value;
        end else begin
            // While held, the writeback entry retires and would drop out of reach
            rs1_q <= op_a;
            rs2_q <= op_b;
        end
    end

    // ==================================================
    // Operands and hazard
    // ==================================================
    always_comb begin
        op_a = resolve_operand(ex_q.rs1, rs1_q);
        op_b = resolve_operand(ex_q.rs2, rs2_q);
        uses_rs2 = ex_q.op inside {pipe_pkg::OP_ADD, pipe_pkg::OP_SUB, pipe_pkg::OP_STORE};

        // Load data only shows up once the load reaches writeback
        load_use_hazard = ex_q.valid && fwd.m_valid && fwd.m_is_load && fwd.m_rd != '0 &&
                          (fwd.m_rd == ex_q.rs1 || (uses_rs2 && fwd.m_rd == ex_q.rs2));
    end

    // ==================================================
    // ALU
    // ==================================================
    always_comb begin
        case (ex_q.op)
            pipe_pkg::OP_ADD: result = op_a + op_b;
            pipe_pkg::OP_SUB: result = op_a - op_b;
            default:          result = op_a + ex_q.imm;
        endcase

        mem_req.valid      = ex_q.valid && !(load_use_hazard && !backend_stall);
        mem_req.is_load    = (ex_q.op == pipe_pkg::OP_LOAD);
        mem_req.is_store   = (ex_q.op == pipe_pkg::OP_STORE);
        mem_req.rd         = ex_q.rd;
        mem_req.result     = result;
        mem_req.store_data = op_b;
    end

    // The inserted bubble clears the load from memory, so one cycle is enough
    single_cycle_load_use: assert property (@(posedge clock) disable iff (reset)
        load_use_hazard && !backend_stall |=> !load_use_hazard)
        else $error("load-use stall held for more than one cycle");

endmodule

`default_nettype wire

/* memory_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module memory_stage (
    input  logic                 clock,
    input  logic                 reset,
    input  pipe_pkg::mem_req_t   mem_req,
    input  logic                 backend_stall,
    fwd_if.producer              fwd,
    output pipe_pkg::reg_write_t reg_write,
    output logic                 mmio_valid,
    output logic [`XLEN-1:0]     mmio_addr,
    output logic [`XLEN-1:0]     mmio_data
);
    localparam int RAM_AW = $clog2(`RAM_WORDS);

    pipe_pkg::mem_req_t mem_q;
    logic [`XLEN-1:0]   ram [`RAM_WORDS];
    logic [`XLEN-1:0]   ram_rdata;
    logic [RAM_AW-1:0]  ram_index;
    logic               is_mmio;
    logic               ram_write;
    logic               wb_valid;
    logic               wb_is_load;
    pipe_pkg::reg_idx_t wb_rd;
    logic [`XLEN-1:0]   wb_result;

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_q.valid <= 1'b0;
        end else if (!backend_stall) begin
            mem_q <= mem_req;
        end
    end

    assign is_mmio   = (mem_q.result >= `MMIO_BASE);
    assign ram_index = mem_q.result[RAM_AW+1:2];
    assign ram_write = mem_q.valid && mem_q.is_store && !is_mmio;

    // Synchronous read, the data lines up with the writeback register
    always_ff @(posedge clock) begin
        if (ram_write) begin
            ram[ram_index] <= mem_q.store_data;
        end
        if (!backend_stall) begin
            ram_rdata <= ram[ram_index];
        end
    end

    assign mmio_valid = mem_q.valid && mem_q.is_store && is_mmio;
    assign mmio_addr  = mem_q.result;
    assign mmio_data  = mem_q.store_data;

    // ==================================================
    // Writeback
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else if (!backend_stall) begin
            wb_valid   <= mem_q.valid && !mem_q.is_store && mem_q.rd != '0;
            wb_is_load <= mem_q.is_load;
            wb_rd      <= mem_q.rd;
            wb_result  <= mem_q.result;
        end
    end

    always_comb begin
        reg_write.enable = wb_valid;
        reg_write.rd     = wb_rd;
        reg_write.value  = wb_is_load ? ram_rdata : wb_result;
    end

    assign fwd.m_valid   = mem_q.valid && !mem_q.is_store;
    assign fwd.m_is_load = mem_q.is_load;
    assign fwd.m_rd      = mem_q.rd;
    assign fwd.m_value   = mem_q.result;
    assign fwd.w_valid   = wb_valid;
    assign fwd.w_rd      = wb_rd;
    assign fwd.w_value   = reg_write.value;

    mmio_held_steady: assert property (@(posedge clock) disable iff (reset)
        backend_stall |=> mmio_valid && $stable(mmio_addr) && $stable(mmio_data))
        else $error("MMIO request changed while waiting for ready");

    ram_access_in_range: assert property (@(posedge clock) disable iff (reset)
        mem_q.valid && (mem_q.is_load || ram_write) |-> mem_q.result[`XLEN-1:2] < `RAM_WORDS)
        else $error("RAM access at %h outside the data RAM", mem_q.result);

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             instr_valid,
    output logic             instr_ready,
    input  logic [`XLEN-1:0] instr_bits,
    output logic             mmio_valid,
    input  logic             mmio_ready,
    output logic [`XLEN-1:0] mmio_addr,
    output logic [`XLEN-1:0] mmio_data
);
    pipe_pkg::decoded_t   decoded;
    pipe_pkg::mem_req_t   mem_req;
    pipe_pkg::reg_write_t reg_write;
    logic [`XLEN-1:0]     rs1_value;
    logic [`XLEN-1:0]     rs2_value;
    logic                 load_use_hazard;
    logic                 backend_stall;
    logic                 frontend_stall;

    fwd_if fwd ();

    // A pending MMIO write freezes everything behind it as well
    assign backend_stall  = mmio_valid && !mmio_ready;
    assign frontend_stall = backend_stall || load_use_hazard;
    assign instr_ready    = !frontend_stall;

    decode_stage u_decode (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_bits  (instr_bits),
        .stall       (frontend_stall),
        .reg_write   (reg_write),
        .decoded     (decoded),
        .rs1_value   (rs1_value),
        .rs2_value   (rs2_value)
    );

    execute_stage u_execute (
        .clock           (clock),
        .reset           (reset),
        .decoded         (decoded),
        .rs1_value       (rs1_value),
        .rs2_value       (rs2_value),
        .frontend_stall  (frontend_stall),
        .backend_stall   (backend_stall),
        .fwd             (fwd.consumer),
        .mem_req         (mem_req),
        .load_use_hazard (load_use_hazard)
    );

    memory_stage u_memory (
        .clock         (clock),
        .reset         (reset),
        .mem_req       (mem_req),
        .backend_stall (backend_stall),
        .fwd           (fwd.producer),
        .reg_write     (reg_write),
        .mmio_valid    (mmio_valid),
        .mmio_addr     (mmio_addr),
        .mmio_data     (mmio_data)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD_NS = 4,
    parameter int RESET_CYCLES   = 3
) (
    output logic clock,
    output logic reset
);
    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD_NS) clock = ~clock;
    end

    // Reset falls right after the last of its rising edges
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
    end
endmodule

`default_nettype wire

/* core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_tb;
    localparam int PROG_LEN   = 400;
    localparam int TIMEOUT    = PROG_LEN * 12;
    localparam int N_PROLOGUE = 7 + `RAM_WORDS;
    localparam int N_EPILOGUE = 8;
    localparam int RAM_AW     = $clog2(`RAM_WORDS);

    localparam int KIND_ADD  = 0;
    localparam int KIND_SUB  = 1;
    localparam int KIND_ADDI = 2;
    localparam int KIND_LW   = 3;
    localparam int KIND_SW   = 4;
    localparam int KIND_BAD  = 5;

    logic             clock;
    logic             reset;
    logic             instr_valid;
    logic             instr_ready;
    logic [`XLEN-1:0] instr_bits;
    logic             mmio_valid;
    logic             mmio_ready;
    logic [`XLEN-1:0] mmio_addr;
    logic [`XLEN-1:0] mmio_data;

    int               prog_kind [PROG_LEN];
    logic [4:0]       prog_rd   [PROG_LEN];
    logic [4:0]       prog_rs1  [PROG_LEN];
    logic [4:0]       prog_rs2  [PROG_LEN];
    logic [`XLEN-1:0] prog_imm  [PROG_LEN];
    logic [`XLEN-1:0] prog_word [PROG_LEN];
    logic [`XLEN-1:0] model_regs [`REG_COUNT];
    logic [`XLEN-1:0] model_ram  [`RAM_WORDS];
    logic [63:0]      exp_mmio [$];
    logic             head_valid;
    logic [`XLEN-1:0] head_addr;
    logic [`XLEN-1:0] head_data;
    logic             last_wait;
    logic [`XLEN-1:0] last_addr;
    logic [`XLEN-1:0] last_data;
    int               sent_count;
    int               offered;
    int               cycle_count;
    int               backpressure_cycles;
    int               hazard_cycles;
    logic [31:0]      rng;

    tb_clock_gen clock_gen (
        .clock (clock),
        .reset (reset)
    );

    core_top dut (
        .clock       (clock),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr_ready (instr_ready),
        .instr_bits  (instr_bits),
        .mmio_valid  (mmio_valid),
        .mmio_ready  (mmio_ready),
        .mmio_addr   (mmio_addr),
        .mmio_data   (mmio_data)
    );

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    // RV32I encodings, written out from the ISA tables
    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [31:0] imm, input logic [31:0] noise);
        case (kind)
            KIND_ADD:  return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            KIND_SUB:  return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            KIND_ADDI: return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            KIND_LW:   return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            KIND_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            default:   return {noise[31:7], 7'b0001011};
        endcase
    endfunction

    task automatic set_instr(input int i, input int kind, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [31:0] imm);
        logic [31:0] noise;
        draw(noise);
        prog_kind[i] = kind;
        prog_rd[i]   = rd;
        prog_rs1[i]  = rs1;
        prog_rs2[i]  = rs2;
        prog_imm[i]  = imm;
        prog_word[i] = encode(kind, rd, rs1, rs2, imm, noise);
    endtask

    // Seed x1..x7, fill every RAM word, random body, then dump x0..x7 over MMIO
    task automatic build_program();
        int          i;
        int          kind;
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] imm;
        for (i = 1; i < 8; i++) begin
            draw(r);
            set_instr(i - 1, KIND_ADDI, 5'(i), 5'd0, 5'd0, {{20{r[11]}}, r[11:0]});
        end
        for (i = 0; i < `RAM_WORDS; i++) begin
            set_instr(7 + i, KIND_SW, 5'd0, 5'd0, 5'(i % 7 + 1), 32'(i * 4));
        end
        for (i = N_PROLOGUE; i < PROG_LEN - N_EPILOGUE; i++) begin
            draw(r);
            draw(s);
            imm = {{20{s[11]}}, s[11:0]};
            if (r[3:0] < 3) begin
                kind = KIND_ADD;
            end else if (r[3:0] < 5) begin
                kind = KIND_SUB;
            end else if (r[3:0] < 8) begin
                kind = KIND_ADDI;
            end else if (r[3:0] < 12) begin
                kind = r[3:0] < 10 ? KIND_LW : KIND_SW;
                imm = {24'd0, s[RAM_AW-1:0], 2'b00};
            end else if (r[3:0] < 15) begin
                kind = KIND_SW;
                imm = `MMIO_BASE + {26'd0, s[3:0], 2'b00};
            end else begin
                kind = KIND_BAD;
            end
            if (kind == KIND_LW || kind == KIND_SW) begin
                set_instr(i, kind, kind == KIND_SW ? 5'd0 : 5'(r[6:4]), 5'd0,
                          5'(r[12:10]), imm);
            end else begin
                set_instr(i, kind, 5'(r[6:4]), 5'(r[9:7]), 5'(r[12:10]), imm);
            end
        end
        for (i = 0; i < N_EPILOGUE; i++) begin
            set_instr(PROG_LEN - N_EPILOGUE + i, KIND_SW, 5'd0, 5'd0, 5'(i),
                      `MMIO_BASE + 32'(i * 4));
        end
    endtask

    // ==================================================
    // Reference model, in program order
    // ==================================================
    task automatic run_model(input int i);
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] v;
        a = model_regs[prog_rs1[i]];
        b = model_regs[prog_rs2[i]];
        addr = a + prog_imm[i];
        v = '0;
        case (prog_kind[i])
            KIND_ADD:  v = a + b;
            KIND_SUB:  v = a - b;
            KIND_ADDI: v = addr;
            KIND_LW:   v = model_ram[addr[RAM_AW+1:2]];
            KIND_SW: begin
                if (addr >= `MMIO_BASE) begin
                    exp_mmio.push_back({addr, b});
                end else begin
                    model_ram[addr[RAM_AW+1:2]] = b;
                end
            end
            default: ;
        endcase
        if (prog_kind[i] <= KIND_LW && prog_rd[i] != 5'd0) begin
            model_regs[prog_rd[i]] = v;
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            sent_count          <= 0;
            head_valid          <= 1'b0;
            last_wait           <= 1'b0;
            cycle_count         <= 0;
            backpressure_cycles <= 0;
            hazard_cycles       <= 0;
        end else begin
            if (mmio_valid && mmio_ready && exp_mmio.size() != 0) begin
                void'(exp_mmio.pop_front());
            end
            if (instr_valid && instr_ready) begin
                run_model(sent_count);
                sent_count <= sent_count + 1;
            end
            head_valid <= exp_mmio.size() != 0;
            if (exp_mmio.size() != 0) begin
                head_addr <= exp_mmio[0][63:32];
                head_data <= exp_mmio[0][31:0];
            end
            last_wait <= mmio_valid && !mmio_ready;
            last_addr <= mmio_addr;
            last_data <= mmio_data;
            if (mmio_valid && !mmio_ready) begin
                backpressure_cycles <= backpressure_cycles + 1;
            end
            if (!instr_ready && !(mmio_valid && !mmio_ready)) begin
                hazard_cycles <= hazard_cycles + 1;
            end
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT) begin
                fail_run($sformatf("run did not finish within %0d cycles", TIMEOUT));
            end
        end
    end

    // ==================================================
    // Checks
    // ==================================================
    mmio_expected: assert property (@(posedge clock) disable iff (reset)
        mmio_valid && mmio_ready |-> head_valid)
        else fail_run("MMIO write seen while the model expects none");

    mmio_addr_match: assert property (@(posedge clock) disable iff (reset)
        mmio_valid && mmio_ready && head_valid |-> mmio_addr == head_addr)
        else fail_run($sformatf("mismatch mmio_addr got %h expected %h",
                                $sampled(mmio_addr), $sampled(head_addr)));

    mmio_data_match: assert property (@(posedge clock) disable iff (reset)
        mmio_valid && mmio_ready && head_valid |-> mmio_data == head_data)
        else fail_run($sformatf("mismatch mmio_data got %h expected %h",
                                $sampled(mmio_data), $sampled(head_data)));

    mmio_valid_held: assert property (@(posedge clock) disable iff (reset)
        last_wait |-> mmio_valid)
        else fail_run("mmio_valid dropped before mmio_ready was seen");

    mmio_addr_held: assert property (@(posedge clock) disable iff (reset)
        last_wait |-> mmio_addr == last_addr)
        else fail_run($sformatf("mismatch mmio_addr got %h expected %h while waiting",
                                $sampled(mmio_addr), $sampled(last_addr)));

    mmio_data_held: assert property (@(posedge clock) disable iff (reset)
        last_wait |-> mmio_data == last_data)
        else fail_run($sformatf("mismatch mmio_data got %h expected %h while waiting",
                                $sampled(mmio_data), $sampled(last_data)));

    intake_blocked: assert property (@(posedge clock) disable iff (reset)
        mmio_valid && !mmio_ready |-> !instr_ready)
        else fail_run("instr_ready high while an MMIO write waits");

    idle_after_reset: assert property (@(posedge clock) disable iff (reset)
        $fell(reset) |-> instr_ready && !mmio_valid)
        else fail_run("pipeline not idle and ready in the first cycle after reset");

    // ==================================================
    // Stimulus
    // ==================================================
    initial begin
        instr_valid = 1'b0;
        instr_bits  = '0;
        mmio_ready  = 1'b0;
        rng         = 32'ha463;
        offered     = 0;
        foreach (model_regs[k]) begin
            model_regs[k] = '0;
        end
        build_program();

        @(negedge clock);
        while (reset) begin
            @(negedge clock);
        end
        while (sent_count < PROG_LEN || head_valid) begin
            // An offered word stays put until it is taken
            if (!instr_valid || sent_count != offered) begin
                if (sent_count >= PROG_LEN) begin
                    instr_valid = 1'b0;
                end else begin
                    offered     = sent_count;
                    instr_bits  = prog_word[offered];
                    instr_valid = (xorshift(rng) % 4) != 0;
                    rng         = xorshift(rng);
                end
            end
            rng = xorshift(rng);
            mmio_ready = (rng % 3) != 0;
            @(negedge clock);
        end

        // Idle tail, any stray MMIO write now trips the checks
        mmio_ready = 1'b1;
        repeat (8) @(negedge clock);

        if (hazard_cycles == 0 || backpressure_cycles == 0) begin
            fail_run("load-use stall or MMIO back-pressure never happened");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end
endmodule

`default_nettype wire

/* verilog.f */
+incdir+.
rv_isa_pkg.sv
pipe_pkg.sv
pipe_ifs.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
core_top.sv
tb_clock_gen.sv
core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
RTL_TOP   ?= core_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RTL_SRCS  ?= rv_isa_pkg.sv pipe_pkg.sv pipe_ifs.sv decode_stage.sv \
             execute_stage.sv memory_stage.sv core_top.sv

SOURCES := $(wildcard *.sv *.svh) $(FILELIST)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only -Wall +incdir+. --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)
